// File: rob_core_consts.svh
`ifndef ROB_CORE_CONSTS_SVH
`define ROB_CORE_CONSTS_SVH

// reorder buffer geometry
`define ROB_DEPTH 8
`define ROB_TAG_W 3

// instruction queue depth
`define IQ_DEPTH 4

`define XLEN 32

// status block register offsets
`define APB_OCC     32'h0000_0000
`define APB_COMMITS 32'h0000_0004
`define APB_FLUSHES 32'h0000_0008
`define APB_CTRL    32'h0000_000C

`endif

// File: rob_core_pkg.sv
`include "rob_core_consts.svh"

package rob_core_pkg;

	// RV32I major opcodes
	typedef enum logic [6:0] {
		op_lui   = 7'b0110111,
		op_auipc = 7'b0010111,
		op_jal   = 7'b1101111,
		op_jalr  = 7'b1100111,
		op_br    = 7'b1100011,
		op_load  = 7'b0000011,
		op_store = 7'b0100011,
		op_imm   = 7'b0010011,
		op_reg   = 7'b0110011
	} opcode_e;

	// decoded instruction with its front-end prediction
	typedef struct packed {
		opcode_e opcode;
		logic [`XLEN-1:0] pc;
		logic [4:0] rd;
		logic br_pred;
		logic [`XLEN-1:0] branch_pc;
	} pci_t;

	// completion or broadcast record
	typedef struct packed {
		logic valid;
		logic [`ROB_TAG_W-1:0] tag;
		logic [`XLEN-1:0] data;
	} sal_t;

	typedef struct packed {
		pci_t pc_info;
		logic [`XLEN-1:0] data;
		logic rdy;
		logic valid;
	} rob_entry_t;

	// instruction handed to a station group
	typedef struct packed {
		pci_t pc_info;
		logic [`ROB_TAG_W-1:0] tag;
	} dispatch_t;

	// retired instruction toward the register file
	typedef struct packed {
		logic valid;
		logic [4:0] rd;
		logic we;
		logic [`XLEN-1:0] data;
		logic [`ROB_TAG_W-1:0] tag;
	} commit_t;

endpackage

// File: rob_queue.sv
`timescale 1ns/1ns
`include "rob_core_consts.svh"

module rob_queue #(
	parameter type payload_t = logic [7:0]
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     flush_i,
	input  logic     push_i,
	input  payload_t data_i,
	input  logic     pop_i,
	output payload_t head_o,
	output logic     full_o,
	output logic     empty_o
);
	localparam int DEPTH = `IQ_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t mem [DEPTH];
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [CNT_W-1:0] count;
	logic do_push;
	logic do_pop;

	assign full_o  = (count == CNT_W'(DEPTH));
	assign empty_o = (count == '0);
	assign head_o  = mem[rd_ptr];

	// a push into a full queue or a pop from an empty one is ignored
	assign do_push = push_i && !full_o;
	assign do_pop  = pop_i && !empty_o;

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= data_i;
		end
	end

	// depth is a power of two so the pointers wrap on their own
	always_ff @(posedge clk) begin
		if (rst || flush_i) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: rob_dispatch.sv
`timescale 1ns/1ns
`include "rob_core_consts.svh"

module rob_dispatch (
	input  rob_core_pkg::pci_t      head_i,
	input  logic                    empty_i,
	input  logic                    stall_br_i,
	input  logic                    stall_acu_i,
	input  logic                    stall_lsq_i,
	input  logic                    rob_full_i,
	input  logic [`ROB_TAG_W-1:0]   alloc_tag_i,
	output logic                    alloc_o,
	output logic                    load_br_o,
	output logic                    load_acu_o,
	output logic                    load_lsq_o,
	output rob_core_pkg::dispatch_t disp_o
);
	logic is_br;
	logic is_acu;
	logic is_lsq;
	logic group_free;

	// station group by opcode
	always_comb begin
		is_br  = 1'b0;
		is_acu = 1'b0;
		is_lsq = 1'b0;
		case (head_i.opcode)
			rob_core_pkg::op_jal,
			rob_core_pkg::op_jalr,
			rob_core_pkg::op_br:    is_br  = 1'b1;
			rob_core_pkg::op_imm,
			rob_core_pkg::op_reg,
			rob_core_pkg::op_auipc: is_acu = 1'b1;
			rob_core_pkg::op_lui,
			rob_core_pkg::op_load,
			rob_core_pkg::op_store: is_lsq = 1'b1;
			// unknown opcodes match no group and stay at the queue head
			default: ;
		endcase
	end

	assign group_free = (is_br && !stall_br_i) ||
	                    (is_acu && !stall_acu_i) ||
	                    (is_lsq && !stall_lsq_i);

	// pop the queue and allocate the ROB entry together
	assign alloc_o = !empty_i && !rob_full_i && group_free;

	assign load_br_o  = alloc_o && is_br;
	assign load_acu_o = alloc_o && is_acu;
	assign load_lsq_o = alloc_o && is_lsq;

	assign disp_o.pc_info = head_i;
	assign disp_o.tag     = alloc_tag_i;

endmodule

// File: reorder_buffer.sv
`timescale 1ns/1ns
`include "rob_core_consts.svh"

module reorder_buffer (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    alloc_i,
	input  rob_core_pkg::pci_t      alloc_pci_i,
	output logic [`ROB_TAG_W-1:0]   alloc_tag_o,
	output logic                    full_o,
	input  rob_core_pkg::sal_t      br_cpl_i,
	input  rob_core_pkg::sal_t      acu_cpl_i,
	input  rob_core_pkg::sal_t      lsq_cpl_i,
	output rob_core_pkg::sal_t      broadcast_o,
	output rob_core_pkg::commit_t   commit_o,
	output logic                    flush_o,
	output logic [`XLEN-1:0]        flush_pc_o,
	output logic [`ROB_TAG_W:0]     occupancy_o
);
	localparam int DEPTH = `ROB_DEPTH;
	localparam int CNT_W = `ROB_TAG_W + 1;

	rob_core_pkg::rob_entry_t arr [DEPTH];
	rob_core_pkg::rob_entry_t head_ent;
	rob_core_pkg::sal_t cpl [3];
	logic [2:0] cpl_ok;
	logic [`ROB_TAG_W-1:0] head;
	logic [`ROB_TAG_W-1:0] tail;
	logic [CNT_W-1:0] count;
	logic retire;
	logic mispredict;
	logic is_br;
	logic is_jalr;
	logic is_jal;
	logic is_store;
	logic [`XLEN-1:0] link_pc;

	assign alloc_tag_o = tail;
	assign occupancy_o = count;

	// a flush wipes every entry at this edge so nothing is allocated in that cycle
	assign full_o = (count == CNT_W'(DEPTH)) || flush_o;

	// index order is broadcast priority from low to high
	assign cpl[0] = br_cpl_i;
	assign cpl[1] = acu_cpl_i;
	assign cpl[2] = lsq_cpl_i;

	always_comb begin
		for (int i = 0; i < 3; i++) begin
			cpl_ok[i] = cpl[i].valid && arr[cpl[i].tag].valid;
		end
	end

	assign head_ent = arr[head];
	assign retire   = head_ent.valid && head_ent.rdy;
	assign is_br    = (head_ent.pc_info.opcode == rob_core_pkg::op_br);
	assign is_jalr  = (head_ent.pc_info.opcode == rob_core_pkg::op_jalr);
	assign is_jal   = (head_ent.pc_info.opcode == rob_core_pkg::op_jal);
	assign is_store = (head_ent.pc_info.opcode == rob_core_pkg::op_store);
	assign link_pc  = head_ent.pc_info.pc + `XLEN'(4);

	// jumps write the return address and branches or stores write nothing
	always_comb begin
		commit_o.valid = retire;
		commit_o.rd    = head_ent.pc_info.rd;
		commit_o.we    = !(is_br || is_store);
		commit_o.tag   = head;
		if (is_jal || is_jalr) begin
			commit_o.data = link_pc;
		end else begin
			commit_o.data = head_ent.data;
		end
	end

	// branch data bit 0 is the taken flag and jalr data is the resolved target
	always_comb begin
		mispredict = 1'b0;
		flush_pc_o = link_pc;
		if (is_br) begin
			mispredict = (head_ent.data[0] != head_ent.pc_info.br_pred);
			if (head_ent.data[0]) begin
				flush_pc_o = head_ent.pc_info.branch_pc;
			end
		end else if (is_jalr) begin
			mispredict = (head_ent.data != head_ent.pc_info.branch_pc);
			flush_pc_o = head_ent.data;
		end
	end

	assign flush_o = retire && mispredict;

	always_ff @(posedge clk) begin
		if (rst) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
			for (int i = 0; i < DEPTH; i++) begin
				arr[i].valid <= 1'b0;
				arr[i].rdy   <= 1'b0;
			end
		end else begin
			for (int i = 0; i < 3; i++) begin
				if (cpl_ok[i]) begin
					arr[cpl[i].tag].data <= cpl[i].data;
					arr[cpl[i].tag].rdy  <= 1'b1;
				end
			end
			if (alloc_i) begin
				arr[tail].pc_info <= alloc_pci_i;
				arr[tail].rdy     <= 1'b0;
				arr[tail].valid   <= 1'b1;
				tail              <= tail + 1'b1;
			end
			if (flush_o) begin
				// the mispredicted head retires and all younger entries go
				for (int i = 0; i < DEPTH; i++) begin
					arr[i].valid <= 1'b0;
				end
				head  <= head + 1'b1;
				tail  <= head + 1'b1;
				count <= '0;
			end else begin
				if (retire) begin
					arr[head].valid <= 1'b0;
					head            <= head + 1'b1;
				end
				case ({alloc_i, retire})
					2'b10:   count <= count + 1'b1;
					2'b01:   count <= count - 1'b1;
					default: count <= count;
				endcase
			end
		end
	end

	// one broadcast per cycle even when several ports complete
	always_ff @(posedge clk) begin
		if (rst) begin
			broadcast_o.valid <= 1'b0;
		end else begin
			broadcast_o.valid <= 1'b0;
			for (int i = 0; i < 3; i++) begin
				if (cpl_ok[i]) begin
					broadcast_o <= cpl[i];
				end
			end
		end
	end

endmodule

// File: rob_status_apb.sv
`timescale 1ns/1ns
`include "rob_core_consts.svh"

module rob_status_apb (
	input  logic                clk,
	input  logic                rst,
	input  logic                psel_i,
	input  logic                penable_i,
	input  logic                pwrite_i,
	input  logic [`XLEN-1:0]    paddr_i,
	input  logic [`XLEN-1:0]    pwdata_i,
	output logic [`XLEN-1:0]    prdata_o,
	output logic                pready_o,
	output logic                pslverr_o,
	input  logic                commit_i,
	input  logic                flush_i,
	input  logic [`ROB_TAG_W:0] occupancy_i
);
	logic [`XLEN-1:0] commit_cnt;
	logic [`XLEN-1:0] flush_cnt;
	logic access;
	logic addr_hit;
	logic clear;

	assign access   = psel_i && penable_i;
	// word aligned offsets 0x0 to 0xC
	assign addr_hit = (paddr_i[`XLEN-1:4] == '0) && (paddr_i[1:0] == 2'b00);
	assign clear    = access && pwrite_i && (paddr_i == `APB_CTRL) && pwdata_i[0];

	// zero wait states
	assign pready_o  = 1'b1;
	assign pslverr_o = access && !addr_hit;

	always_comb begin
		case (paddr_i)
			`APB_OCC:     prdata_o = `XLEN'(occupancy_i);
			`APB_COMMITS: prdata_o = commit_cnt;
			`APB_FLUSHES: prdata_o = flush_cnt;
			default:      prdata_o = '0;
		endcase
	end

	// a clear wins over a same-cycle event
	always_ff @(posedge clk) begin
		if (rst || clear) begin
			commit_cnt <= '0;
			flush_cnt  <= '0;
		end else begin
			if (commit_i) begin
				commit_cnt <= commit_cnt + 1'b1;
			end
			if (flush_i) begin
				flush_cnt <= flush_cnt + 1'b1;
			end
		end
	end

endmodule

// File: rob_core.sv
`timescale 1ns/1ns
`include "rob_core_consts.svh"

module rob_core (
	input  logic                    clk,
	input  logic                    rst,
	input  rob_core_pkg::pci_t      instr_i,
	input  logic                    instr_valid_i,
	output logic                    instr_ready_o,
	input  logic                    stall_br_i,
	input  logic                    stall_acu_i,
	input  logic                    stall_lsq_i,
	output logic                    load_br_o,
	output logic                    load_acu_o,
	output logic                    load_lsq_o,
	output rob_core_pkg::dispatch_t disp_o,
	input  rob_core_pkg::sal_t      br_cpl_i,
	input  rob_core_pkg::sal_t      acu_cpl_i,
	input  rob_core_pkg::sal_t      lsq_cpl_i,
	output rob_core_pkg::sal_t      broadcast_o,
	output rob_core_pkg::commit_t   commit_o,
	output logic                    flush_o,
	output logic [`XLEN-1:0]        flush_pc_o,
	input  logic                    psel_i,
	input  logic                    penable_i,
	input  logic                    pwrite_i,
	input  logic [`XLEN-1:0]        paddr_i,
	input  logic [`XLEN-1:0]        pwdata_i,
	output logic [`XLEN-1:0]        prdata_o,
	output logic                    pready_o,
	output logic                    pslverr_o
);
	rob_core_pkg::pci_t iq_head;
	logic iq_full;
	logic iq_empty;
	logic alloc;
	logic rob_full;
	logic [`ROB_TAG_W-1:0] alloc_tag;
	logic [`ROB_TAG_W:0] occupancy;

	assign instr_ready_o = !iq_full;

	rob_queue #(
		.payload_t(rob_core_pkg::pci_t)
	) i_iq (
		.clk     (clk),
		.rst     (rst),
		.flush_i (flush_o),
		.push_i  (instr_valid_i),
		.data_i  (instr_i),
		.pop_i   (alloc),
		.head_o  (iq_head),
		.full_o  (iq_full),
		.empty_o (iq_empty)
	);

	rob_dispatch i_dispatch (
		.head_i      (iq_head),
		.empty_i     (iq_empty),
		.stall_br_i  (stall_br_i),
		.stall_acu_i (stall_acu_i),
		.stall_lsq_i (stall_lsq_i),
		.rob_full_i  (rob_full),
		.alloc_tag_i (alloc_tag),
		.alloc_o     (alloc),
		.load_br_o   (load_br_o),
		.load_acu_o  (load_acu_o),
		.load_lsq_o  (load_lsq_o),
		.disp_o      (disp_o)
	);

	reorder_buffer i_rob (
		.clk         (clk),
		.rst         (rst),
		.alloc_i     (alloc),
		.alloc_pci_i (iq_head),
		.alloc_tag_o (alloc_tag),
		.full_o      (rob_full),
		.br_cpl_i    (br_cpl_i),
		.acu_cpl_i   (acu_cpl_i),
		.lsq_cpl_i   (lsq_cpl_i),
		.broadcast_o (broadcast_o),
		.commit_o    (commit_o),
		.flush_o     (flush_o),
		.flush_pc_o  (flush_pc_o),
		.occupancy_o (occupancy)
	);

	rob_status_apb i_status (
		.clk         (clk),
		.rst         (rst),
		.psel_i      (psel_i),
		.penable_i   (penable_i),
		.pwrite_i    (pwrite_i),
		.paddr_i     (paddr_i),
		.pwdata_i    (pwdata_i),
		.prdata_o    (prdata_o),
		.pready_o    (pready_o),
		.pslverr_o   (pslverr_o),
		.commit_i    (commit_o.valid),
		.flush_i     (flush_o),
		.occupancy_i (occupancy)
	);

endmodule

// File: tb_rob_core_assert.sv
`timescale 1ns/1ns
`include "rob_core_consts.svh"

module tb_rob_core_assert (
	input logic                    clk,
	input logic                    rst,
	input logic                    instr_ready_o,
	input logic                    stall_br_i,
	input logic                    stall_acu_i,
	input logic                    stall_lsq_i,
	input logic                    load_br_o,
	input logic                    load_acu_o,
	input logic                    load_lsq_o,
	input rob_core_pkg::dispatch_t disp_o,
	input rob_core_pkg::sal_t      br_cpl_i,
	input rob_core_pkg::sal_t      acu_cpl_i,
	input rob_core_pkg::sal_t      lsq_cpl_i,
	input rob_core_pkg::sal_t      broadcast_o,
	input rob_core_pkg::commit_t   commit_o,
	input logic                    flush_o,
	input logic [`XLEN-1:0]        flush_pc_o,
	input logic                    pslverr_o,
	input logic                    rob_full_i
);
	int fail_cnt = 0;
	rob_core_pkg::pci_t sh_pci [`ROB_DEPTH];
	logic [`XLEN-1:0] sh_data [`ROB_DEPTH];
	logic [`ROB_TAG_W-1:0] exp_tag;
	rob_core_pkg::pci_t c_pci;
	logic [`XLEN-1:0] c_data;
	logic c_br;
	logic c_jalr;
	logic c_jump;
	logic exp_we;
	logic [`XLEN-1:0] exp_wdata;
	logic exp_flush;
	logic [`XLEN-1:0] exp_fpc;
	logic d_br;
	logic d_acu;
	logic d_lsq;

	// shadow copy of what was dispatched and completed, per tag
	always_ff @(posedge clk) begin
		if (load_br_o || load_acu_o || load_lsq_o) begin
			sh_pci[disp_o.tag] <= disp_o.pc_info;
		end
		if (br_cpl_i.valid) begin
			sh_data[br_cpl_i.tag] <= br_cpl_i.data;
		end
		if (acu_cpl_i.valid) begin
			sh_data[acu_cpl_i.tag] <= acu_cpl_i.data;
		end
		if (lsq_cpl_i.valid) begin
			sh_data[lsq_cpl_i.tag] <= lsq_cpl_i.data;
		end
	end

	// a flush retires the head too, so tags always step by one
	always_ff @(posedge clk) begin
		if (rst) begin
			exp_tag <= '0;
		end else if (commit_o.valid) begin
			exp_tag <= commit_o.tag + 1'b1;
		end
	end

	always_comb begin
		c_pci  = sh_pci[commit_o.tag];
		c_data = sh_data[commit_o.tag];
		c_br   = (c_pci.opcode == rob_core_pkg::op_br);
		c_jalr = (c_pci.opcode == rob_core_pkg::op_jalr);
		c_jump = c_jalr || (c_pci.opcode == rob_core_pkg::op_jal);
		exp_we = !(c_br || (c_pci.opcode == rob_core_pkg::op_store));
		exp_wdata = c_jump ? (c_pci.pc + 32'd4) : c_data;
		exp_flush = 1'b0;
		exp_fpc   = c_pci.pc + 32'd4;
		if (c_br) begin
			exp_flush = (c_data[0] != c_pci.br_pred);
			if (c_data[0]) begin
				exp_fpc = c_pci.branch_pc;
			end
		end else if (c_jalr) begin
			exp_flush = (c_data != c_pci.branch_pc);
			exp_fpc   = c_data;
		end
		d_br  = disp_o.pc_info.opcode inside {rob_core_pkg::op_jal, rob_core_pkg::op_jalr,
		                                      rob_core_pkg::op_br};
		d_acu = disp_o.pc_info.opcode inside {rob_core_pkg::op_imm, rob_core_pkg::op_reg,
		                                      rob_core_pkg::op_auipc};
		d_lsq = disp_o.pc_info.opcode inside {rob_core_pkg::op_lui, rob_core_pkg::op_load,
		                                      rob_core_pkg::op_store};
	end

	a_order: assert property (@(posedge clk) disable iff (rst)
		commit_o.valid |-> commit_o.tag == exp_tag)
		else begin
			fail_cnt++;
			$error("commit out of program order");
		end

	a_commit_data: assert property (@(posedge clk) disable iff (rst)
		commit_o.valid |-> (commit_o.rd == c_pci.rd) && (commit_o.we == exp_we) &&
		                   (commit_o.data == exp_wdata))
		else begin
			fail_cnt++;
			$error("commit rd, we or data wrong");
		end

	a_onehot: assert property (@(posedge clk) disable iff (rst)
		$onehot0({load_br_o, load_acu_o, load_lsq_o}))
		else begin
			fail_cnt++;
			$error("more than one load strobe");
		end

	a_route_br: assert property (@(posedge clk) disable iff (rst)
		load_br_o |-> d_br && !stall_br_i && !rob_full_i)
		else begin
			fail_cnt++;
			$error("bad branch dispatch");
		end

	a_route_acu: assert property (@(posedge clk) disable iff (rst)
		load_acu_o |-> d_acu && !stall_acu_i && !rob_full_i)
		else begin
			fail_cnt++;
			$error("bad arithmetic dispatch");
		end

	a_route_lsq: assert property (@(posedge clk) disable iff (rst)
		load_lsq_o |-> d_lsq && !stall_lsq_i && !rob_full_i)
		else begin
			fail_cnt++;
			$error("bad load/store dispatch");
		end

	a_flush: assert property (@(posedge clk) disable iff (rst)
		flush_o |-> commit_o.valid && exp_flush && (flush_pc_o == exp_fpc))
		else begin
			fail_cnt++;
			$error("flush without mispredict or wrong pc");
		end

	a_miss_flush: assert property (@(posedge clk) disable iff (rst)
		(commit_o.valid && exp_flush) |-> flush_o)
		else begin
			fail_cnt++;
			$error("mispredict retired without flush");
		end

	a_flush_gap: assert property (@(posedge clk) disable iff (rst)
		flush_o |=> !commit_o.valid)
		else begin
			fail_cnt++;
			$error("commit right after flush");
		end

	// lsq has the highest broadcast priority, then acu, then br
	a_bc_lsq: assert property (@(posedge clk) disable iff (rst)
		lsq_cpl_i.valid |=> broadcast_o == $past(lsq_cpl_i))
		else begin
			fail_cnt++;
			$error("lsq broadcast wrong");
		end

	a_bc_acu: assert property (@(posedge clk) disable iff (rst)
		acu_cpl_i.valid && !lsq_cpl_i.valid |=> broadcast_o == $past(acu_cpl_i))
		else begin
			fail_cnt++;
			$error("acu broadcast wrong");
		end

	a_bc_br: assert property (@(posedge clk) disable iff (rst)
		br_cpl_i.valid && !acu_cpl_i.valid && !lsq_cpl_i.valid
		|=> broadcast_o == $past(br_cpl_i))
		else begin
			fail_cnt++;
			$error("br broadcast wrong");
		end

	a_bc_idle: assert property (@(posedge clk) disable iff (rst)
		!br_cpl_i.valid && !acu_cpl_i.valid && !lsq_cpl_i.valid |=> !broadcast_o.valid)
		else begin
			fail_cnt++;
			$error("broadcast without completion");
		end

	a_reset: assert property (@(posedge clk)
		rst |=> instr_ready_o && !commit_o.valid && !flush_o && !load_br_o &&
		        !load_acu_o && !load_lsq_o && !broadcast_o.valid && !pslverr_o)
		else begin
			fail_cnt++;
			$error("outputs active after reset");
		end

endmodule

bind rob_core tb_rob_core_assert i_chk (
	.clk           (clk),
	.rst           (rst),
	.instr_ready_o (instr_ready_o),
	.stall_br_i    (stall_br_i),
	.stall_acu_i   (stall_acu_i),
	.stall_lsq_i   (stall_lsq_i),
	.load_br_o     (load_br_o),
	.load_acu_o    (load_acu_o),
	.load_lsq_o    (load_lsq_o),
	.disp_o        (disp_o),
	.br_cpl_i      (br_cpl_i),
	.acu_cpl_i     (acu_cpl_i),
	.lsq_cpl_i     (lsq_cpl_i),
	.broadcast_o   (broadcast_o),
	.commit_o      (commit_o),
	.flush_o       (flush_o),
	.flush_pc_o    (flush_pc_o),
	.pslverr_o     (pslverr_o),
	.rob_full_i    (rob_full)
);

// File: tb_rob_core.sv
`timescale 1ns/1ns
`include "rob_core_consts.svh"

module tb_rob_core;
	logic clk;
	logic rst;
	rob_core_pkg::pci_t instr;
	logic instr_valid;
	logic instr_ready;
	logic stall_br;
	logic stall_acu;
	logic stall_lsq;
	logic load_br;
	logic load_acu;
	logic load_lsq;
	rob_core_pkg::dispatch_t disp;
	rob_core_pkg::sal_t br_cpl;
	rob_core_pkg::sal_t acu_cpl;
	rob_core_pkg::sal_t lsq_cpl;
	rob_core_pkg::sal_t broadcast;
	rob_core_pkg::commit_t commit;
	logic flush;
	logic [`XLEN-1:0] flush_pc;
	logic psel;
	logic penable;
	logic pwrite;
	logic [`XLEN-1:0] paddr;
	logic [`XLEN-1:0] pwdata;
	logic [`XLEN-1:0] prdata;
	logic pready;
	logic pslverr;

	// station models hold dispatched instructions until they complete
	rob_core_pkg::dispatch_t q_br[$];
	rob_core_pkg::dispatch_t q_acu[$];
	rob_core_pkg::dispatch_t q_lsq[$];
	// accepted instructions still waiting in the instruction queue, oldest first
	rob_core_pkg::pci_t pending[$];
	int in_rob = 0;
	int errors = 0;
	int n_commit = 0;
	int n_flush = 0;
	int n_accept = 0;
	int idx;
	logic hold_cpl;
	logic stall_rand;
	logic saw_not_ready;
	logic [`XLEN-1:0] next_pc;

	rob_core i_dut (
		.clk(clk), .rst(rst),
		.instr_i(instr), .instr_valid_i(instr_valid), .instr_ready_o(instr_ready),
		.stall_br_i(stall_br), .stall_acu_i(stall_acu), .stall_lsq_i(stall_lsq),
		.load_br_o(load_br), .load_acu_o(load_acu), .load_lsq_o(load_lsq),
		.disp_o(disp),
		.br_cpl_i(br_cpl), .acu_cpl_i(acu_cpl), .lsq_cpl_i(lsq_cpl),
		.broadcast_o(broadcast), .commit_o(commit),
		.flush_o(flush), .flush_pc_o(flush_pc),
		.psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
		.paddr_i(paddr), .pwdata_i(pwdata), .prdata_o(prdata),
		.pready_o(pready), .pslverr_o(pslverr)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic rob_core_pkg::pci_t gen_instr();
		rob_core_pkg::pci_t p;
		case ($urandom_range(8, 0))
			0: p.opcode = rob_core_pkg::op_lui;
			1: p.opcode = rob_core_pkg::op_auipc;
			2: p.opcode = rob_core_pkg::op_jal;
			3: p.opcode = rob_core_pkg::op_jalr;
			4: p.opcode = rob_core_pkg::op_br;
			5: p.opcode = rob_core_pkg::op_load;
			6: p.opcode = rob_core_pkg::op_store;
			7: p.opcode = rob_core_pkg::op_imm;
			default: p.opcode = rob_core_pkg::op_reg;
		endcase
		p.pc      = next_pc;
		next_pc   = next_pc + 32'd4;
		p.rd      = 5'($urandom);
		p.br_pred = 1'($urandom);
		p.branch_pc = $urandom & 32'hffff_fffc;
		return p;
	endfunction

	// branch bit 0 is a random outcome, jalr hits its predicted target half the time
	function automatic rob_core_pkg::sal_t make_result(rob_core_pkg::dispatch_t d);
		rob_core_pkg::sal_t r;
		r.valid = 1'b1;
		r.tag   = d.tag;
		r.data  = $urandom;
		if (d.pc_info.opcode == rob_core_pkg::op_jalr && $urandom_range(1, 0) == 1) begin
			r.data = d.pc_info.branch_pc;
		end
		return r;
	endfunction

	always @(posedge clk) begin
		if (rst) begin
			q_br.delete();
			q_acu.delete();
			q_lsq.delete();
			pending.delete();
			in_rob = 0;
		end else begin
			if (commit.valid) n_commit++;
			if (instr_valid && instr_ready) n_accept++;
			if (!instr_ready) saw_not_ready = 1'b1;
			if (flush) begin
				n_flush++;
				q_br.delete();
				q_acu.delete();
				q_lsq.delete();
				// the queue goes too, including an instruction taken at this edge
				pending.delete();
				in_rob = 0;
			end else begin
				if (load_br || load_acu || load_lsq) begin
					if (pending.size() == 0) begin
						errors++;
						$display("dispatch of an instruction that was never accepted");
					end else begin
						if (disp.pc_info !== pending[0]) begin
							errors++;
							$display("MISMATCH dispatch order expected %h actual %h",
							         pending[0], disp.pc_info);
						end
						pending.delete(0);
					end
					in_rob++;
				end
				if (commit.valid) in_rob--;
				if (instr_valid && instr_ready) pending.push_back(instr);
			end
			if (load_br) q_br.push_back(disp);
			if (load_acu) q_acu.push_back(disp);
			if (load_lsq) q_lsq.push_back(disp);
		end
	end

	// completions and stalls change on the falling edge
	always @(negedge clk) begin
		br_cpl  = '0;
		acu_cpl = '0;
		lsq_cpl = '0;
		if (!rst && !hold_cpl) begin
			if (q_br.size() > 0 && $urandom_range(3, 0) == 0) begin
				idx = $urandom_range(q_br.size() - 1, 0);
				br_cpl = make_result(q_br[idx]);
				q_br.delete(idx);
			end
			if (q_acu.size() > 0 && $urandom_range(3, 0) == 0) begin
				idx = $urandom_range(q_acu.size() - 1, 0);
				acu_cpl = make_result(q_acu[idx]);
				q_acu.delete(idx);
			end
			if (q_lsq.size() > 0 && $urandom_range(3, 0) == 0) begin
				idx = $urandom_range(q_lsq.size() - 1, 0);
				lsq_cpl = make_result(q_lsq[idx]);
				q_lsq.delete(idx);
			end
		end
		if (stall_rand) begin
			stall_br  = ($urandom_range(5, 0) == 0);
			stall_acu = ($urandom_range(5, 0) == 0);
			stall_lsq = ($urandom_range(5, 0) == 0);
		end
	end

	task automatic abort_on_timeout(input string what);
		$display("timeout while waiting for %s", what);
		$display("Test failed");
		$finish;
	endtask

	task automatic check_value(input string name, input int expected, input int actual);
		if (expected != actual) begin
			errors++;
			$display("MISMATCH %s expected %0d actual %0d", name, expected, actual);
		end
	endtask

	// a new instruction is offered once the previous one was taken
	task automatic run_program(input int cycles);
		logic took;
		for (int i = 0; i < cycles; i++) begin
			@(posedge clk);
			took = instr_valid && instr_ready;
			@(negedge clk);
			if (took || !instr_valid) begin
				instr = gen_instr();
				instr_valid = 1'b1;
			end
		end
	endtask

	task automatic apb_access(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
	                          output logic [31:0] rdata, output logic err);
		int t;
		@(negedge clk);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = wdata;
		@(negedge clk);
		penable = 1'b1;
		t = 0;
		while (pready !== 1'b1) begin
			@(negedge clk);
			t++;
			if (t > 50) abort_on_timeout("APB pready");
		end
		@(posedge clk);
		rdata = prdata;
		err   = pslverr;
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	initial begin
		logic [31:0] d;
		logic e;
		int t;
		logic idle;
		void'($urandom(32'ha5d7));
		rst = 1'b1;
		instr = '0;
		instr_valid = 1'b0;
		{stall_br, stall_acu, stall_lsq} = 3'b000;
		br_cpl = '0;
		acu_cpl = '0;
		lsq_cpl = '0;
		{psel, penable, pwrite} = 3'b000;
		paddr = '0;
		pwdata = '0;
		hold_cpl = 1'b0;
		stall_rand = 1'b0;
		saw_not_ready = 1'b0;
		next_pc = 32'h0000_1000;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		apb_access(1'b0, `APB_COMMITS, 0, d, e);
		check_value("reset commits", 0, int'(d));
		apb_access(1'b0, `APB_FLUSHES, 0, d, e);
		check_value("reset flushes", 0, int'(d));

		stall_rand = 1'b1;
		run_program(300);
		// stations stop returning results so the ROB and queue fill up
		hold_cpl = 1'b1;
		run_program(40);
		hold_cpl = 1'b0;
		run_program(150);

		@(negedge clk);
		instr_valid = 1'b0;
		stall_rand = 1'b0;
		{stall_br, stall_acu, stall_lsq} = 3'b000;
		t = 0;
		idle = 1'b0;
		while (!idle) begin
			apb_access(1'b0, `APB_OCC, 0, d, e);
			idle = (d == 0) && i_dut.iq_empty;
			t++;
			if (t > 500) abort_on_timeout("pipeline drain");
		end
		if (!saw_not_ready) begin
			errors++;
			$display("instr_ready_o never dropped under back-pressure");
		end
		if (n_flush == 0) begin
			errors++;
			$display("no mispredict flush happened during the run");
		end
		// everything accepted since the last flush has been dispatched and committed
		check_value("instructions left in queue", 0, pending.size());
		check_value("instructions left in ROB", 0, in_rob);

		apb_access(1'b0, `APB_COMMITS, 0, d, e);
		check_value("commit counter", n_commit, int'(d));
		apb_access(1'b0, `APB_FLUSHES, 0, d, e);
		check_value("flush counter", n_flush, int'(d));
		apb_access(1'b1, `APB_CTRL, 32'h1, d, e);
		apb_access(1'b0, `APB_COMMITS, 0, d, e);
		check_value("cleared commits", 0, int'(d));
		apb_access(1'b0, `APB_FLUSHES, 0, d, e);
		check_value("cleared flushes", 0, int'(d));
		apb_access(1'b0, 32'h0000_0010, 0, d, e);
		check_value("unmapped pslverr", 1, int'(e));

		$display("accepted %0d, committed %0d, flushes %0d, errors %0d, assertion failures %0d",
		         n_accept, n_commit, n_flush, errors, i_dut.i_chk.fail_cnt);
		if (errors == 0 && i_dut.i_chk.fail_cnt == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: rob_core.f
+incdir+.
rob_core_pkg.sv
rob_queue.sv
rob_dispatch.sv
reorder_buffer.sv
rob_status_apb.sv
rob_core.sv
tb_rob_core_assert.sv
tb_rob_core.sv

// File: Makefile
TOP = tb_rob_core

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check run.log"
	@echo "  clean  remove build output and run.log"
	@echo "  help   show this list"

test:
	verilator --binary --assert --timing -Wno-fatal --top-module $(TOP) -f rob_core.f -o Vtb
	./obj_dir/Vtb +verilator+error+limit+1000 > run.log 2>&1 || true
	@cat run.log
	@if grep -q "Test failed" run.log; then echo "FAIL"; exit 1; fi
	@grep -q "Test completed successfully" run.log

clean:
	rm -rf obj_dir run.log
